//--- common/rename_pkg.sv
package rename_pkg;

  // ##############################
  // architectural register file

  localparam int num_arch = 32; // fixed by the 5-bit register fields

  typedef logic [4:0] arch_reg_t;

  // ##############################
  // instruction encoding

  typedef enum logic [5:0] {
    op_alu    = 6'h01, // rd <- rs1 op rs2
    op_alui   = 6'h02, // rd <- rs1 op imm
    op_store  = 6'h03, // mem[rs1 + imm] <- rd field
    op_branch = 6'h04  // compares rs1 with the rd field
  } opcode_t;

  // register-register view
  typedef struct packed {
    opcode_t     opcode;
    arch_reg_t   rd;
    arch_reg_t   rs1;
    arch_reg_t   rs2;
    logic [10:0] funct;
  } r_format_t;

  // immediate view, also used by stores and branches
  typedef struct packed {
    opcode_t     opcode;
    arch_reg_t   rd;
    arch_reg_t   rs1;
    logic [15:0] imm;
  } i_format_t;

  // opcode, rd and rs1 line up in both views
  typedef union packed {
    r_format_t r;
    i_format_t i;
  } instr_t;

endpackage

//--- src/inst_decoder.sv
module inst_decoder import rename_pkg::*; (
  input  instr_t    instr,
  output arch_reg_t dest_arch,
  output logic      has_dest,
  output arch_reg_t src1_arch,
  output arch_reg_t src2_arch,
  output logic      is_branch
);

  always_comb begin
    dest_arch = '0;
    src1_arch = '0;
    src2_arch = '0;
    is_branch = 1'b0;
    case (instr.r.opcode)
      op_alu: begin
        dest_arch = instr.r.rd;
        src1_arch = instr.r.rs1;
        src2_arch = instr.r.rs2; // only the r view carries rs2
      end
      op_alui: begin
        dest_arch = instr.i.rd;
        src1_arch = instr.i.rs1;
      end
      op_store: begin
        src1_arch = instr.i.rs1;  // base address
        src2_arch = instr.i.rd;   // store data
      end
      op_branch: begin
        src1_arch = instr.i.rs1;
        src2_arch = instr.i.rd;
        is_branch = 1'b1;
      end
      default: begin
        // unknown opcode renames nothing
        dest_arch = '0;
      end
    endcase
  end

  // writes to r0 are dropped, so they never take a physical register
  assign has_dest = (dest_arch != '0);

endmodule

//--- free_list/free_list.sv
module free_list import rename_pkg::*; #(
  parameter  int num_phys = 64,
  localparam int num_fl   = num_phys - num_arch,
  localparam int phys_w   = $clog2(num_phys),
  localparam int ptr_w    = $clog2(num_fl) + 1,
  localparam int slot_w   = ptr_w - 1
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              alloc_en,
  input  logic              release_en,
  input  logic [phys_w-1:0] release_phys,
  input  logic              rollback_en,
  input  logic [ptr_w-1:0]  rollback_idx,
  output logic [phys_w-1:0] alloc_phys,
  output logic [ptr_w-1:0]  alloc_idx,
  output logic              empty
);

  logic [phys_w-1:0] fl_table [num_fl];
  logic [ptr_w-1:0]  alloc_ptr;   // next register handed out
  logic [ptr_w-1:0]  release_ptr; // next slot written back
  logic              no_free;

  // pointers run over twice the table size so full and empty differ
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(2 * num_fl - 1)) ? '0 : p + 1'b1;
  endfunction

  function automatic logic [slot_w-1:0] slot(input logic [ptr_w-1:0] p);
    logic [ptr_w-1:0] s;
    s = (p >= ptr_w'(num_fl)) ? p - ptr_w'(num_fl) : p;
    return s[slot_w-1:0];
  endfunction

  // ##############################
  // allocation side

  assign no_free   = (alloc_ptr == release_ptr);
  assign empty     = no_free && !release_en; // a release this cycle can be handed on
  assign alloc_idx = alloc_en ? ptr_inc(alloc_ptr) : alloc_ptr; // saved in the ROB for rollback

  always_comb begin
    if (no_free)
      alloc_phys = release_phys; // forward the register being freed
    else
      alloc_phys = fl_table[slot(alloc_ptr)];
  end

  // ##############################
  // pointer and table update

  always_ff @(posedge clock) begin
    if (reset) begin
      alloc_ptr   <= '0;
      release_ptr <= ptr_w'(num_fl);
      for (int i = 0; i < num_fl; i++) begin
        fl_table[i] <= phys_w'(num_arch + i);
      end
    end else begin
      if (release_en) begin
        fl_table[slot(release_ptr)] <= release_phys;
        release_ptr                 <= ptr_inc(release_ptr);
      end
      if (rollback_en)
        alloc_ptr <= rollback_idx; // squashed allocations come back
      else if (alloc_en)
        alloc_ptr <= alloc_idx;
    end
  end

  a_no_alloc_when_empty: assert property (
    @(posedge clock) disable iff (reset) alloc_en |-> !empty
  ) else $error("free list allocated while empty");

endmodule

//--- map_table/map_table.sv
module map_table import rename_pkg::*; #(
  parameter  int num_phys = 64,
  localparam int phys_w   = $clog2(num_phys)
) (
  input  logic              clock,
  input  logic              reset,
  input  arch_reg_t         src1_arch,
  input  arch_reg_t         src2_arch,
  input  arch_reg_t         dest_arch,
  input  logic              rename_en,
  input  logic [phys_w-1:0] dest_phys,
  output logic [phys_w-1:0] src1_phys,
  output logic [phys_w-1:0] src2_phys,
  output logic [phys_w-1:0] told_phys,
  input  logic              commit_en,
  input  arch_reg_t         commit_arch,
  input  logic [phys_w-1:0] commit_phys,
  input  logic              restore_en
);

  logic [phys_w-1:0] spec_map  [num_arch];
  logic [phys_w-1:0] arch_map  [num_arch];
  logic [phys_w-1:0] arch_next [num_arch];

  // lookups see the map before this cycle's rename
  assign src1_phys = spec_map[src1_arch];
  assign src2_phys = spec_map[src2_arch];
  assign told_phys = spec_map[dest_arch];

  // committed state including the retirement in flight
  always_comb begin
    arch_next = arch_map;
    if (commit_en)
      arch_next[commit_arch] = commit_phys;
  end

  // ##############################
  // map update

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        spec_map[i] <= phys_w'(i); // identity mapping
        arch_map[i] <= phys_w'(i);
      end
    end else begin
      arch_map <= arch_next;
      if (restore_en)
        spec_map <= arch_next;
      else if (rename_en)
        spec_map[dest_arch] <= dest_phys;
    end
  end

  a_no_rename_r0: assert property (
    @(posedge clock) disable iff (reset) rename_en |-> dest_arch != '0
  ) else $error("rename of r0");

  // r0 must keep physical 0 through renames, commits and restores
  a_r0_pinned: assert property (
    @(posedge clock) disable iff (reset) spec_map[0] == '0 && arch_map[0] == '0
  ) else $error("r0 mapping moved");

endmodule

//--- reorder_buffer/reorder_buffer.sv
module reorder_buffer import rename_pkg::*; #(
  parameter  int rob_depth = 16,
  parameter  int num_phys  = 64,
  localparam int idx_w     = $clog2(rob_depth),
  localparam int cnt_w     = $clog2(rob_depth + 1),
  localparam int phys_w    = $clog2(num_phys),
  localparam int fl_w      = $clog2(num_phys - num_arch) + 1
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              dispatch_en,
  input  arch_reg_t         dest_arch,
  input  logic [phys_w-1:0] dest_phys,
  input  logic [phys_w-1:0] told_phys,
  input  logic [fl_w-1:0]   fl_idx,
  output logic [idx_w-1:0]  rob_idx,
  output logic              full,
  input  logic              complete_valid,
  input  logic [idx_w-1:0]  complete_idx,
  input  logic              complete_mispredict,
  output logic              retire_valid,
  output arch_reg_t         retire_arch,
  output logic [phys_w-1:0] retire_phys,
  output logic [phys_w-1:0] retire_told,
  output logic [fl_w-1:0]   retire_fl_idx,
  output logic              flush
);

  // entry payload
  arch_reg_t         entry_arch [rob_depth];
  logic [phys_w-1:0] entry_phys [rob_depth];
  logic [phys_w-1:0] entry_told [rob_depth];
  logic [fl_w-1:0]   entry_fl   [rob_depth];

  // entry status
  logic [rob_depth-1:0] done_q;
  logic [rob_depth-1:0] mispred_q;
  logic [idx_w-1:0]     head;
  logic [idx_w-1:0]     tail;
  logic [cnt_w-1:0]     count;

  function automatic logic [idx_w-1:0] next_idx(input logic [idx_w-1:0] i);
    return (i == idx_w'(rob_depth - 1)) ? '0 : i + 1'b1;
  endfunction

  assign rob_idx = tail;
  assign full    = (count == cnt_w'(rob_depth));

  // ##############################
  // retirement from the head

  assign retire_valid  = (count != '0) && done_q[head];
  assign retire_arch   = entry_arch[head];
  assign retire_phys   = entry_phys[head];
  assign retire_told   = entry_told[head];
  assign retire_fl_idx = entry_fl[head];
  assign flush         = retire_valid && mispred_q[head]; // squash everything younger

  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      entry_arch[tail] <= dest_arch;
      entry_phys[tail] <= dest_phys;
      entry_told[tail] <= told_phys;
      entry_fl[tail]   <= fl_idx;
    end
  end

  // ##############################
  // pointers and status bits

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      done_q    <= '0;
      mispred_q <= '0;
    end else begin
      if (complete_valid) begin
        done_q[complete_idx]    <= 1'b1;
        mispred_q[complete_idx] <= complete_mispredict;
      end
      if (dispatch_en) begin
        done_q[tail]    <= 1'b0;
        mispred_q[tail] <= 1'b0;
        tail            <= next_idx(tail);
      end
      if (retire_valid)
        head <= next_idx(head);
      count <= count + cnt_w'(dispatch_en) - cnt_w'(retire_valid);
    end
  end

  a_no_dispatch_when_full: assert property (
    @(posedge clock) disable iff (reset) dispatch_en |-> !full
  ) else $error("dispatch into a full ROB");

endmodule

//--- src/rename_core.sv
module rename_core import rename_pkg::*; #(
  parameter  int num_phys  = 64,
  parameter  int rob_depth = 16,
  localparam int phys_w    = $clog2(num_phys),
  localparam int idx_w     = $clog2(rob_depth),
  localparam int fl_w      = $clog2(num_phys - num_arch) + 1
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              instr_valid,
  input  instr_t            instr,
  output logic              stall,
  output logic              rename_valid,
  output logic [idx_w-1:0]  rob_idx,
  output logic [phys_w-1:0] dest_phys,
  output logic [phys_w-1:0] src1_phys,
  output logic [phys_w-1:0] src2_phys,
  output logic [phys_w-1:0] told_phys,
  input  logic              complete_valid,
  input  logic [idx_w-1:0]  complete_idx,
  input  logic              complete_mispredict,
  output logic              retire_valid,
  output arch_reg_t         retire_arch,
  output logic [phys_w-1:0] retire_phys,
  output logic [phys_w-1:0] retire_told,
  output logic              flush
);

  arch_reg_t         dec_dest_arch;
  arch_reg_t         dec_src1_arch;
  arch_reg_t         dec_src2_arch;
  logic              has_dest;
  logic              dispatch;
  logic              alloc_en;
  logic              release_en;
  logic              commit_en;
  logic              fl_empty;
  logic              rob_full;
  logic [phys_w-1:0] alloc_phys;
  logic [phys_w-1:0] new_dest_phys;
  logic [phys_w-1:0] map_src1_phys;
  logic [phys_w-1:0] map_src2_phys;
  logic [phys_w-1:0] map_told_phys;
  logic [fl_w-1:0]   alloc_idx;
  logic [fl_w-1:0]   retire_fl_idx;
  logic [idx_w-1:0]  rob_tail;

  // ##############################
  // dispatch control

  assign stall         = (fl_empty && has_dest) || rob_full || flush;
  assign dispatch      = instr_valid && !stall;
  assign alloc_en      = dispatch && has_dest;
  assign new_dest_phys = has_dest ? alloc_phys : '0; // no destination means p0
  assign release_en    = retire_valid && (retire_told != '0);
  assign commit_en     = retire_valid && (retire_arch != '0);

  inst_decoder u_decoder (
    .instr     (instr),
    .dest_arch (dec_dest_arch),
    .has_dest  (has_dest),
    .src1_arch (dec_src1_arch),
    .src2_arch (dec_src2_arch),
    .is_branch ()
  );

  free_list #(.num_phys(num_phys)) u_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_en     (alloc_en),
    .release_en   (release_en),
    .release_phys (retire_told),
    .rollback_en  (flush),
    .rollback_idx (retire_fl_idx),
    .alloc_phys   (alloc_phys),
    .alloc_idx    (alloc_idx),
    .empty        (fl_empty)
  );

  map_table #(.num_phys(num_phys)) u_map_table (
    .clock       (clock),
    .reset       (reset),
    .src1_arch   (dec_src1_arch),
    .src2_arch   (dec_src2_arch),
    .dest_arch   (dec_dest_arch),
    .rename_en   (alloc_en),
    .dest_phys   (new_dest_phys),
    .src1_phys   (map_src1_phys),
    .src2_phys   (map_src2_phys),
    .told_phys   (map_told_phys),
    .commit_en   (commit_en),
    .commit_arch (retire_arch),
    .commit_phys (retire_phys),
    .restore_en  (flush)
  );

  reorder_buffer #(.rob_depth(rob_depth), .num_phys(num_phys)) u_rob (
    .clock               (clock),
    .reset               (reset),
    .dispatch_en         (dispatch),
    .dest_arch           (dec_dest_arch),
    .dest_phys           (new_dest_phys),
    .told_phys           (map_told_phys),
    .fl_idx              (alloc_idx),
    .rob_idx             (rob_tail),
    .full                (rob_full),
    .complete_valid      (complete_valid),
    .complete_idx        (complete_idx),
    .complete_mispredict (complete_mispredict),
    .retire_valid        (retire_valid),
    .retire_arch         (retire_arch),
    .retire_phys         (retire_phys),
    .retire_told         (retire_told),
    .retire_fl_idx       (retire_fl_idx),
    .flush               (flush)
  );

  // ##############################
  // registered rename results

  always_ff @(posedge clock) begin
    if (reset)
      rename_valid <= 1'b0;
    else
      rename_valid <= dispatch; // one pulse per dispatched instruction
  end

  always_ff @(posedge clock) begin
    if (dispatch) begin
      rob_idx   <= rob_tail;
      dest_phys <= new_dest_phys;
      src1_phys <= map_src1_phys;
      src2_phys <= map_src2_phys;
      told_phys <= map_told_phys;
    end
  end

endmodule

//--- test/rename_core_tb.sv
module rename_core_tb import rename_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_phys   = 40; // small free list so it can run dry
  localparam int rob_depth  = 16;
  localparam int phys_w     = $clog2(num_phys);
  localparam int idx_w      = $clog2(rob_depth);
  localparam int num_cycles = 600;

  logic              clock = 1'b0;
  logic              reset;
  logic              instr_valid;
  instr_t            instr;
  logic              complete_valid;
  logic [idx_w-1:0]  complete_idx;
  logic              complete_mispredict;
  logic              stall, rename_valid, retire_valid, flush;
  logic [idx_w-1:0]  rob_idx;
  logic [phys_w-1:0] dest_phys, src1_phys, src2_phys, told_phys;
  logic [phys_w-1:0] retire_phys, retire_told;
  arch_reg_t         retire_arch;

  rename_core #(.num_phys(num_phys), .rob_depth(rob_depth)) dut (.*);

  always #20 clock = ~clock;

  // ##############################
  // shadow model state

  logic [phys_w-1:0] spec_m [num_arch];
  logic [phys_w-1:0] arch_m [num_arch];
  logic [phys_w-1:0] free_q [$];
  arch_reg_t         e_arch [$];
  logic [phys_w-1:0] e_phys [$];
  logic [phys_w-1:0] e_told [$];
  logic [idx_w-1:0]  e_idx  [$];
  logic              e_done [$];
  logic              e_mis  [$];
  logic [idx_w-1:0]  tail_m;

  // expectations for the coming edge, settled at the falling edge
  logic              exp_retire = 1'b0, exp_flush = 1'b0, exp_stall = 1'b0;
  logic              exp_release = 1'b0, exp_dispatch = 1'b0, d_has = 1'b0;
  arch_reg_t         exp_r_arch = '0, d_dd = '0;
  logic [phys_w-1:0] exp_r_phys = '0, exp_r_told = '0;
  logic [phys_w-1:0] d_dest = '0, d_src1 = '0, d_src2 = '0, d_told = '0;
  logic [idx_w-1:0]  d_idx = '0;
  // registered rename expectations
  logic              q_rv = 1'b0;
  logic [phys_w-1:0] q_dest = '0, q_src1 = '0, q_src2 = '0, q_told = '0;
  logic [idx_w-1:0]  q_idx = '0;
  int                flush_seen = 0, full_seen = 0, empty_seen = 0;

  // field layout: opcode 31:26, rd 25:21, rs1 20:16, rs2 15:11
  function automatic void decode_fields(input logic [31:0] w, output arch_reg_t dd,
                                        output arch_reg_t s1, output arch_reg_t s2);
    dd = '0;
    s1 = '0;
    s2 = '0;
    if (w[31:26] == op_alu) begin
      dd = w[25:21];
      s1 = w[20:16];
      s2 = w[15:11];
    end else if (w[31:26] == op_alui) begin
      dd = w[25:21];
      s1 = w[20:16];
    end else if (w[31:26] == op_store || w[31:26] == op_branch) begin
      s1 = w[20:16];
      s2 = w[25:21]; // rd field read as a source
    end
  endfunction

  always @(negedge clock) begin
    arch_reg_t dd, s1, s2;
    decode_fields(instr, dd, s1, s2);
    d_has      = (dd != '0);
    d_dd       = dd;
    exp_retire = (e_arch.size() != 0) && e_done[0];
    exp_flush  = exp_retire && e_mis[0];
    exp_r_arch = exp_retire ? e_arch[0] : '0;
    exp_r_phys = exp_retire ? e_phys[0] : '0;
    exp_r_told = exp_retire ? e_told[0] : '0;
    exp_release = exp_retire && (exp_r_told != '0);
    exp_stall  = (free_q.size() == 0 && !exp_release && d_has) ||
                 (e_arch.size() == rob_depth) || exp_flush;
    exp_dispatch = instr_valid && !exp_stall;
    if (d_has)
      d_dest = (free_q.size() != 0) ? free_q[0] : exp_r_told; // freed reg handed straight on
    else
      d_dest = '0;
    d_told = d_has ? spec_m[dd] : '0;
    d_src1 = spec_m[s1];
    d_src2 = spec_m[s2];
    d_idx  = tail_m;
    if (instr_valid && e_arch.size() == rob_depth) full_seen++;
    if (instr_valid && d_has && free_q.size() == 0 && !exp_release) empty_seen++;
  end

  always @(posedge clock) begin
    if (reset) begin
      free_q.delete();
      for (int i = 0; i < num_arch; i++) begin
        spec_m[i] = phys_w'(i);
        arch_m[i] = phys_w'(i);
      end
      for (int i = num_arch; i < num_phys; i++) free_q.push_back(phys_w'(i));
      e_arch.delete(); e_phys.delete(); e_told.delete();
      e_idx.delete(); e_done.delete(); e_mis.delete();
      tail_m = '0;
      q_rv  <= 1'b0;
    end else begin
      q_rv <= exp_dispatch;
      if (exp_dispatch) begin
        q_dest <= d_dest;
        q_src1 <= d_src1;
        q_src2 <= d_src2;
        q_told <= d_told;
        q_idx  <= d_idx;
      end
      if (complete_valid && !exp_flush) begin
        for (int i = 0; i < e_idx.size(); i++) begin
          if (e_idx[i] == complete_idx) begin
            e_done[i] = 1'b1;
            e_mis[i]  = complete_mispredict;
          end
        end
      end
      if (exp_retire && exp_r_arch != '0) arch_m[exp_r_arch] = exp_r_phys;
      if (exp_flush) begin
        flush_seen++;
        // younger allocations go back ahead of the free registers
        for (int i = e_phys.size() - 1; i >= 1; i--)
          if (e_phys[i] != '0) free_q.push_front(e_phys[i]);
        if (exp_release) free_q.push_back(exp_r_told);
        e_arch.delete(); e_phys.delete(); e_told.delete();
        e_idx.delete(); e_done.delete(); e_mis.delete();
        spec_m = arch_m;
        tail_m = '0;
      end else begin
        if (exp_retire) begin
          void'(e_arch.pop_front()); void'(e_phys.pop_front()); void'(e_told.pop_front());
          void'(e_idx.pop_front()); void'(e_done.pop_front()); void'(e_mis.pop_front());
        end
        if (exp_release) free_q.push_back(exp_r_told);
        if (exp_dispatch) begin
          if (d_has) begin
            void'(free_q.pop_front());
            spec_m[d_dd] = d_dest;
          end
          e_arch.push_back(d_has ? d_dd : arch_reg_t'(0));
          e_phys.push_back(d_dest);
          e_told.push_back(d_told);
          e_idx.push_back(tail_m);
          e_done.push_back(1'b0);
          e_mis.push_back(1'b0);
          tail_m = tail_m + 1'b1;
        end
      end
    end
  end

  // ##############################
  // checks

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want);
    $display("** FAIL **");
    $fatal(1);
  endtask

  a_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
    else report_mismatch("stall", 32'($sampled(stall)), 32'($sampled(exp_stall)));
  a_retire: assert property (@(posedge clock) disable iff (reset) retire_valid == exp_retire)
    else report_mismatch("retire_valid", 32'($sampled(retire_valid)), 32'($sampled(exp_retire)));
  a_flush: assert property (@(posedge clock) disable iff (reset) flush == exp_flush)
    else report_mismatch("flush", 32'($sampled(flush)), 32'($sampled(exp_flush)));
  a_r_arch: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> retire_arch == exp_r_arch)
    else report_mismatch("retire_arch", 32'($sampled(retire_arch)), 32'($sampled(exp_r_arch)));
  a_r_phys: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> retire_phys == exp_r_phys)
    else report_mismatch("retire_phys", 32'($sampled(retire_phys)), 32'($sampled(exp_r_phys)));
  a_r_told: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> retire_told == exp_r_told)
    else report_mismatch("retire_told", 32'($sampled(retire_told)), 32'($sampled(exp_r_told)));
  a_rv: assert property (@(posedge clock) disable iff (reset) rename_valid == q_rv)
    else report_mismatch("rename_valid", 32'($sampled(rename_valid)), 32'($sampled(q_rv)));
  a_stall_hold: assert property (@(posedge clock) disable iff (reset)
    instr_valid && stall |=> !rename_valid)
    else report_mismatch("rename_valid", 32'($sampled(rename_valid)), 32'h0);
  a_idx: assert property (@(posedge clock) disable iff (reset) rename_valid |-> rob_idx == q_idx)
    else report_mismatch("rob_idx", 32'($sampled(rob_idx)), 32'($sampled(q_idx)));
  a_dest: assert property (@(posedge clock) disable iff (reset)
    rename_valid |-> dest_phys == q_dest)
    else report_mismatch("dest_phys", 32'($sampled(dest_phys)), 32'($sampled(q_dest)));
  a_src1: assert property (@(posedge clock) disable iff (reset)
    rename_valid |-> src1_phys == q_src1)
    else report_mismatch("src1_phys", 32'($sampled(src1_phys)), 32'($sampled(q_src1)));
  a_src2: assert property (@(posedge clock) disable iff (reset)
    rename_valid |-> src2_phys == q_src2)
    else report_mismatch("src2_phys", 32'($sampled(src2_phys)), 32'($sampled(q_src2)));
  a_told: assert property (@(posedge clock) disable iff (reset)
    rename_valid |-> told_phys == q_told)
    else report_mismatch("told_phys", 32'($sampled(told_phys)), 32'($sampled(q_told)));

  // ##############################
  // stimulus

  task automatic new_instr();
    logic [5:0] op;
    case ($urandom_range(0, 3))
      0: op = op_alu;
      1: op = op_alui;
      2: op = op_store;
      default: op = op_branch;
    endcase
    instr = instr_t'({op, 5'($urandom_range(0, 11)), 5'($urandom_range(0, 11)),
                      5'($urandom_range(0, 11)), 11'($urandom)});
  endtask

  // completes a random pending entry; rate sets how often
  task automatic drive_completion(input int rate, input logic allow_mis);
    int cand [$];
    int k;
    complete_valid      = 1'b0;
    complete_mispredict = 1'b0;
    for (int i = 0; i < e_done.size(); i++)
      if (!e_done[i]) cand.push_back(i);
    if (cand.size() != 0 && $urandom_range(0, 99) < rate) begin
      k = cand[$urandom_range(0, cand.size() - 1)];
      complete_valid      = 1'b1;
      complete_idx        = e_idx[k];
      complete_mispredict = allow_mis && ($urandom_range(0, 11) == 0);
    end
  endtask

  initial begin
    #(40 * 4 * num_cycles);
    $display("watchdog expired before the run finished");
    $display("** FAIL **");
    $fatal(1);
  end

  initial begin
    logic took;
    void'($urandom(42895));
    reset               = 1'b1;
    instr_valid         = 1'b0;
    instr               = '0;
    complete_valid      = 1'b0;
    complete_idx        = '0;
    complete_mispredict = 1'b0;
    took                = 1'b1;
    repeat (2) @(posedge clock);
    #2 reset = 1'b0;
    for (int c = 0; c < num_cycles; c++) begin
      if (took || !instr_valid) new_instr(); // held while stalled
      instr_valid = ($urandom_range(0, 9) != 0);
      drive_completion(((c / 50) % 2 == 0) ? 12 : 60, 1'b1);
      @(negedge clock);
      took = instr_valid && !stall;
      @(posedge clock);
      #2;
    end
    instr_valid = 1'b0;
    while (e_arch.size() != 0) begin
      drive_completion(100, 1'b0);
      @(posedge clock);
      #2;
    end
    complete_valid = 1'b0;
    repeat (3) @(posedge clock);
    if (flush_seen == 0 || full_seen == 0 || empty_seen == 0) begin
      $display("stimulus missed a flush, a full ROB or an empty free list");
      $display("** FAIL **");
      $fatal(1);
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- rename_core.f
common/rename_pkg.sv
src/inst_decoder.sv
free_list/free_list.sv
map_table/map_table.sv
reorder_buffer/reorder_buffer.sv
src/rename_core.sv
test/rename_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rename core testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f rename_core.f \
    --top-module rename_core_tb -o rename_core_sim &&
  ./obj_dir/rename_core_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
